// File: rumble_pkg.sv
//##############################
// Shared types of the main CPU bus
// Address map is fixed by the board
// Only one bus request may be in flight
//##############################
package rumble_pkg;

    localparam int ROM_AW = 18;               // 64 pages of 4 KB
    localparam int RAM_AW = 13;               // 8 KB work RAM
    localparam int OBJ_AW = 9;                // Object engine sees top 512 bytes
    localparam logic [7:0] CAB_PAD = 8'hff;   // Open bus value

    // Address windows, top nibble of the CPU address
    localparam logic [3:0] WIN_IO   = 4'h4;
    localparam logic [3:0] WIN_CHAR = 4'h5;
    localparam logic [3:0] WIN_PAL  = 4'h7;
    localparam logic [3:0] BANK_LO  = 4'h8;   // First banked window
    localparam logic [3:0] BANK_HI  = 4'hb;   // Last banked window

    typedef enum logic [2:0] {
        rg_none,
        rg_ram,
        rg_scr,
        rg_io,
        rg_char,
        rg_pal,
        rg_rom
    } region_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    // Buttons and joysticks are active low
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic [7:0] dip_a;
        logic [7:0] dip_b;
    } cab_in_t;

    typedef struct packed {
        logic       flip;
        logic [9:0] scr_hpos;
        logic [9:0] scr_vpos;
    } video_ctl_t;

endpackage

// File: main_decode.sv
//##############################
// Region decoder, purely combinational
// Region is none outside a bus cycle
// I/O only answers with adr[3] set
//##############################
`timescale 1ns/1ps

module main_decode import rumble_pkg::*; (
    input  wb_req_t req,
    output region_t region
);

    logic       active;
    logic [3:0] win;

    assign active = req.cyc && req.stb;
    assign win    = req.adr[15:12];

    always_comb begin
        region = rg_none;
        if (active) begin
            casez (win)
                4'b000?: region = rg_ram;     // 0x0000-0x1FFF
                4'b001?: region = rg_scr;     // 0x2000-0x3FFF
                WIN_IO: begin
                    if (req.adr[3]) begin
                        region = rg_io;
                    end
                end
                default: begin
                    // Reads hit the program ROM, writes go to video
                    if (!req.we) begin
                        region = rg_rom;
                    end else if (win == WIN_CHAR) begin
                        region = rg_char;
                    end else if (win == WIN_PAL) begin
                        region = rg_pal;
                    end
                end
            endcase
        end
    end

endmodule

// File: bank_map.sv
//##############################
// ROM address translation
// Only bank bits 2-0 select a page
// Address is held between loads
//##############################
`timescale 1ns/1ps

module bank_map import rumble_pkg::*; (
    input  logic              clk,
    input  logic              nRESET,
    input  logic [7:0]        bank,
    input  logic [15:0]       adr,
    input  logic              load,
    output logic [ROM_AW-1:0] rom_addr
);

    logic [3:0] win;
    logic [5:0] page;

    assign win = adr[15:12];

    always_comb begin
        if (win >= BANK_LO && win <= BANK_HI) begin
            page = {1'b1, bank[2:0], adr[13:12]};  // 32 + 4*bank + sub window
        end else begin
            page = {2'b00, win};                   // Fixed pages
        end
    end

    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            rom_addr <= '0;
        end else if (load) begin
            rom_addr <= {page, adr[11:0]};
        end
    end

endmodule

// File: io_regs.sv
//##############################
// Cabinet I/O latches and input mux
// wr must be a single cycle pulse
// Register 7 only acknowledges IRQs
//##############################
`timescale 1ns/1ps

module io_regs import rumble_pkg::*; (
    input  logic        clk,
    input  logic        nRESET,
    input  logic        wr,
    input  logic [2:0]  sel,
    input  logic [7:0]  din,
    input  cab_in_t     cab,
    output logic [7:0]  bank,
    output video_ctl_t  vid,
    output logic [7:0]  snd_latch,
    output logic        irq_ack,
    output logic [7:0]  cab_dout
);

    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            bank      <= '0;
            vid       <= '0;
            snd_latch <= '0;
        end else if (wr) begin
            case (sel)
                3'd0: bank              <= din;
                3'd1: vid.flip          <= ~din[0];   // Screen is mounted upside down
                3'd2: vid.scr_hpos[7:0] <= din;
                3'd3: vid.scr_hpos[9:8] <= din[1:0];
                3'd4: vid.scr_vpos[7:0] <= din;
                3'd5: vid.scr_vpos[9:8] <= din[1:0];
                3'd6: snd_latch         <= din;
                default: ;                            // 7 is the IRQ ack
            endcase
        end
    end

    assign irq_ack = wr && (sel == 3'd7);

    always_comb begin
        case (sel)
            3'd0: cab_dout = {cab.coin,
                              cab.service,
                              1'b1,        // Tilt, never wired
                              2'b11,
                              cab.start};
            3'd1: cab_dout = {2'b11, cab.joy1};
            3'd2: cab_dout = {2'b11, cab.joy2};
            3'd3: cab_dout = cab.dip_a;
            3'd4: cab_dout = cab.dip_b;
            default: cab_dout = CAB_PAD;
        endcase
    end

endmodule

// File: work_ram.sv
//##############################
// 8 KB work RAM, two read ports
// Object port is read only
// Both reads have one cycle latency
//##############################
`timescale 1ns/1ps

module work_ram import rumble_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [RAM_AW-1:0] addr,
    input  logic [7:0]        din,
    output logic [7:0]        dout,
    input  logic [OBJ_AW-1:0] obj_addr,
    output logic [7:0]        obj_dout
);

    logic [7:0] mem [0:(1<<RAM_AW)-1];

    // CPU port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];
    end

    // Object table sits at the top of the RAM
    always_ff @(posedge clk) begin
        obj_dout <= mem[{{(RAM_AW-OBJ_AW){1'b1}}, obj_addr}];
    end

endmodule

// File: irq_gen.sv
//##############################
// Vertical blank and mid screen IRQs
// Lines stay low until acknowledged
// dip_pause low blocks new requests
//##############################
`timescale 1ns/1ps

module irq_gen (
    input  logic clk,
    input  logic nRESET,
    input  logic lvbl,
    input  logic vmid,
    input  logic dip_pause,
    input  logic irq_ack,
    output logic nirq,
    output logic nfirq
);

    logic last_lvbl;
    logic last_vmid;

    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            last_lvbl <= 1'b0;   // No edge seen out of reset
            last_vmid <= 1'b1;
            nirq      <= 1'b1;
            nfirq     <= 1'b1;
        end else begin
            last_lvbl <= lvbl;
            last_vmid <= vmid;
            if (irq_ack) begin
                nirq  <= 1'b1;
                nfirq <= 1'b1;
            end else begin
                if (last_lvbl && !lvbl && dip_pause) nirq  <= 1'b0;  // Blank starts
                if (!last_vmid && vmid && dip_pause) nfirq <= 1'b0;  // Mid screen
            end
        end
    end

endmodule

// File: main_bus.sv
//##############################
// Main CPU bus, Wishbone classic slave
// Master holds the request until ack
// ROM latency is set by rom_ok
// Writes to ROM space are dropped
//##############################
`timescale 1ns/1ps

module main_bus import rumble_pkg::*; (
    input  logic              clk,
    input  logic              nRESET,
    // Wishbone slave
    input  wb_req_t           req,
    output logic              ack,
    output logic [7:0]        dat_o,
    // Cabinet and video timing
    input  cab_in_t           cab,
    input  logic              lvbl,       // Low during vertical blank
    input  logic              vmid,
    input  logic              dip_pause,
    output logic              nirq,
    output logic              nfirq,
    output video_ctl_t        vid,
    output logic [7:0]        snd_latch,
    // Video RAMs
    input  logic [7:0]        char_dout,
    input  logic [7:0]        scr_dout,
    input  logic              char_busy,
    input  logic              scr_busy,
    output logic              char_cs,
    output logic              scr_cs,
    output logic              pal_cs,
    // Program ROM
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [7:0]        rom_data,
    input  logic              rom_ok,
    // Object engine
    input  logic [OBJ_AW-1:0] obj_addr,
    output logic [7:0]        obj_dout
);

    typedef enum logic [1:0] {st_idle, st_wait, st_ack} seq_t;

    seq_t       state;
    region_t    region;
    logic       start;
    logic       ready;
    logic [7:0] bank;
    logic [7:0] ram_dout;
    logic [7:0] cab_dout;
    logic       irq_ack;

    main_decode u_decode (.req(req), .region(region));

    assign start   = (state == st_idle) && req.cyc && req.stb;
    assign scr_cs  = (region == rg_scr);
    assign char_cs = (region == rg_char);
    assign pal_cs  = (region == rg_pal);
    assign ack     = (state == st_ack);

    always_comb begin
        case (region)
            rg_scr:  ready = !scr_busy;
            rg_char: ready = !char_busy;
            rg_rom:  ready = rom_cs && rom_ok;
            default: ready = 1'b1;          // RAM, I/O, palette, dropped writes
        endcase
    end

    // Ack sequencer, first cycle only starts the access
    always_ff @(posedge clk or negedge nRESET) begin
        if (!nRESET) begin
            state  <= st_idle;
            rom_cs <= 1'b0;
        end else begin
            case (state)
                st_idle: if (start) begin
                    state  <= st_wait;
                    rom_cs <= (region == rg_rom);   // Address is loaded this cycle
                end
                st_wait: if (ready) state <= st_ack;
                default: begin
                    state  <= st_idle;
                    rom_cs <= 1'b0;
                end
            endcase
        end
    end

    bank_map u_bank (
        .clk      (clk),
        .nRESET   (nRESET),
        .bank     (bank),
        .adr      (req.adr),
        .load     (start && region == rg_rom),
        .rom_addr (rom_addr)
    );

    io_regs u_io (
        .clk       (clk),
        .nRESET    (nRESET),
        .wr        (start && region == rg_io && req.we),   // Once per access
        .sel       (req.adr[2:0]),
        .din       (req.dat),
        .cab       (cab),
        .bank      (bank),
        .vid       (vid),
        .snd_latch (snd_latch),
        .irq_ack   (irq_ack),
        .cab_dout  (cab_dout)
    );

    work_ram u_ram (
        .clk      (clk),
        .we       (start && region == rg_ram && req.we),
        .addr     (req.adr[RAM_AW-1:0]),
        .din      (req.dat),
        .dout     (ram_dout),
        .obj_addr (obj_addr),
        .obj_dout (obj_dout)
    );

    irq_gen u_irq (
        .clk       (clk),
        .nRESET    (nRESET),
        .lvbl      (lvbl),
        .vmid      (vmid),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .nirq      (nirq),
        .nfirq     (nfirq)
    );

    assign dat_o = (region == rg_rom)  ? rom_data  :
                   (region == rg_ram)  ? ram_dout  :
                   (region == rg_scr)  ? scr_dout  :
                   (region == rg_char) ? char_dout :
                   (region == rg_io)   ? cab_dout  : CAB_PAD;

endmodule

// File: tb_main_bus.sv
//##############################
// Testbench for the main CPU bus
// Plays the CPU on the Wishbone port
// ROM and video RAMs are simple models
//##############################
`timescale 1ns/1ps

module tb_main_bus import rumble_pkg::*; ();

    logic              clk = 1'b0;
    logic              nRESET = 1'b0;
    wb_req_t           req = '0;
    logic              ack;
    logic [7:0]        dat_o;
    cab_in_t           cab = '0;
    logic              lvbl = 1'b1;
    logic              vmid = 1'b0;
    logic              dip_pause = 1'b1;
    logic              nirq, nfirq;
    video_ctl_t        vid;
    logic [7:0]        snd_latch;
    logic [7:0]        char_dout = 8'hc3;
    logic [7:0]        scr_dout = 8'h3c;    // Scroll RAM read pattern
    logic              char_busy = 1'b0;
    logic              scr_busy = 1'b0;
    logic              char_cs, scr_cs, pal_cs;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0]        rom_data = 8'h00;
    logic              rom_ok = 1'b0;
    logic [OBJ_AW-1:0] obj_addr = '0;
    logic [7:0]        obj_dout;

    // Separate random streams from the one seed
    logic [31:0] rnd = 32'hc8d3;
    logic [31:0] busy_rnd = 32'hc8d3 ^ 32'h5555_0000;
    logic [31:0] rom_rnd = 32'hc8d3 ^ 32'haaaa_0000;
    logic [7:0]  ram_shadow [0:(1<<RAM_AW)-1];
    logic [7:0]  bank_sh = 8'h00;
    logic [15:0] ram_list [$];
    logic [7:0]  io_val [0:6];
    logic        rom_cs_q = 1'b0;
    logic        scr_busy_q = 1'b0;
    logic        char_busy_q = 1'b0;
    string       test_name = "reset";
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          age = 0;        // Falling edges since the request appeared

    main_bus main_bus_i (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        rnd = lcg_step(rnd);
        return rnd;
    endfunction

    function automatic logic [7:0] cab_byte(input logic [2:0] s);
        case (s)
            3'd0: return {cab.coin, cab.service, 3'b111, cab.start};
            3'd1: return {2'b11, cab.joy1};
            3'd2: return {2'b11, cab.joy2};
            3'd3: return cab.dip_a;
            3'd4: return cab.dip_b;
            default: return CAB_PAD;
        endcase
    endfunction

    // Banked windows 0x8-0xB map to pages 32 and up
    function automatic logic [ROM_AW-1:0] ref_rom_addr(input logic [15:0] a,
                                                       input logic [7:0] bank);
        int page;
        if (a[15:12] >= 4'h8 && a[15:12] <= 4'hb) begin
            page = 32 + 4 * int'(bank[2:0]) + int'(a[13:12]);
        end else begin
            page = int'(a[15:12]);
        end
        return {page[5:0], a[11:0]};
    endfunction

    function automatic logic [7:0] ref_read(input logic [15:0] a);
        logic [ROM_AW-1:0] ra;
        if (a[15:13] == 3'b000) return ram_shadow[a[12:0]];
        if (a[15:13] == 3'b001) return 8'h3c;
        if (a[15:12] == 4'h4) return a[3] ? cab_byte(a[2:0]) : CAB_PAD;
        ra = ref_rom_addr(a, bank_sh);
        return ra[7:0] ^ ra[17:10];
    endfunction

    // Expected {scr_cs, char_cs, pal_cs}
    function automatic logic [2:0] exp_strobes(input wb_req_t q);
        if (!(q.cyc && q.stb)) return 3'b000;
        return {q.adr[15:13] == 3'b001,
                q.we && q.adr[15:12] == 4'h5,
                q.we && q.adr[15:12] == 4'h7};
    endfunction

    // Program ROM answers reads from 0x5000 up
    function automatic logic rom_read(input wb_req_t q);
        return q.cyc && q.stb && !q.we && q.adr[15:12] >= 4'h5;
    endfunction

    // Accesses that never wait on a device
    function automatic logic fixed_ack(input wb_req_t q);
        return !rom_read(q) && q.adr[15:13] != 3'b001
               && !(q.we && q.adr[15:12] == 4'h5);
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic wait_ack();
        @(negedge clk);
        while (!ack) @(negedge clk);
        @(posedge clk);
        req.cyc <= 1'b0;
        req.stb <= 1'b0;
    endtask

    task automatic wb_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        req <= {3'b111, a, d};
        wait_ack();
        if (a[15:13] == 3'b000) ram_shadow[a[12:0]] = d;
        if (a[15:12] == 4'h4 && a[3:0] == 4'h8) bank_sh = d;
    endtask

    task automatic wb_read(input logic [15:0] a);
        @(posedge clk);
        req <= {3'b110, a, 8'h00};
        wait_ack();                         // Data is checked by the monitor
    endtask

    // ROM answers 0 to 5 cycles after rom_cs
    always @(posedge clk) begin : rom_model
        int cnt;
        if (!rom_cs) begin
            rom_ok <= 1'b0;
            cnt = -1;
        end else if (cnt < 0) begin
            rom_rnd = lcg_step(rom_rnd);
            cnt = int'(rom_rnd[15:8]) % 6;
        end else if (cnt == 0) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_addr[7:0] ^ rom_addr[17:10];
        end else begin
            cnt = cnt - 1;
        end
    end

    always @(posedge clk) begin
        busy_rnd = lcg_step(busy_rnd);
        scr_busy  <= busy_rnd[20:19] != 2'b00;   // Busy three cycles in four
        char_busy <= busy_rnd[23:22] != 2'b00;
    end

    // Monitor of every bus cycle
    always @(negedge clk) begin
        if (req.cyc && req.stb) begin
            age++;
        end else begin
            age = 0;
        end
        if (nRESET) begin
            check_val("strobes", 32'(exp_strobes(req)), 32'({scr_cs, char_cs, pal_cs}));
            // rom_cs follows stb by one cycle and lasts until ack
            check_val("rom_cs", 32'(rom_read(req) && age >= 2), 32'(rom_cs));
            if (!(req.cyc && req.stb)) begin
                check_val("idle ack", 32'(1'b0), 32'(ack));
            end else if (fixed_ack(req)) begin
                check_val("ack latency", 32'(age == 3), 32'(ack));
            end
            if (rom_cs && !rom_cs_q) begin
                check_val("rom_addr", 32'(ref_rom_addr(req.adr, bank_sh)), 32'(rom_addr));
            end
            if (ack && !req.we) check_val("read data", 32'(ref_read(req.adr)), 32'(dat_o));
            if (ack && req.adr[15:13] == 3'b001) begin
                assert (!scr_busy_q) else begin
                    errors++;
                    $display("Scroll access acknowledged while scr_busy was high");
                end
            end
            if (ack && req.we && req.adr[15:12] == 4'h5) begin
                assert (!char_busy_q) else begin
                    errors++;
                    $display("Char write acknowledged while char_busy was high");
                end
            end
        end
        rom_cs_q    = rom_cs;
        scr_busy_q  = scr_busy;
        char_busy_q = char_busy;
    end

    // About 300 accesses of at most 10 cycles, plus margin
    always @(posedge clk) begin
        cycles++;
        if (cycles > 4000) begin
            $display("Timeout after %0d cycles, the bus stopped answering", cycles);
            $display("Checks run %0d, errors %0d", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [15:0] a;
        repeat (4) @(posedge clk);
        nRESET <= 1'b1;

        test_name = "ram";
        for (int k = 0; k < 48; k++) begin
            r = rand_word();
            a = {3'b000, r[12:0]};
            wb_write(a, r[23:16]);
            ram_list.push_back(a);
        end
        while (ram_list.size() > 0) wb_read(ram_list.pop_front());
        test_name = "obj";
        for (int k = 0; k < 16; k++) begin
            r = rand_word();
            a = {7'b0001111, r[8:0]};         // Top 512 bytes
            wb_write(a, r[23:16]);
            ram_list.push_back(a);
        end
        while (ram_list.size() > 0) begin
            a = ram_list.pop_front();
            @(posedge clk);
            obj_addr <= a[8:0];
            @(posedge clk);
            @(negedge clk);
            check_val("obj_dout", 32'(ram_shadow[a[12:0]]), 32'(obj_dout));
        end

        test_name = "io";
        for (int k = 0; k < 7; k++) begin
            r = rand_word();
            io_val[k] = r[7:0];
            wb_write({13'h0801, k[2:0]}, r[7:0]);
        end
        check_val("flip", 32'(!io_val[1][0]), 32'(vid.flip));
        check_val("hpos", 32'({io_val[3][1:0], io_val[2]}), 32'(vid.scr_hpos));
        check_val("vpos", 32'({io_val[5][1:0], io_val[4]}), 32'(vid.scr_vpos));
        check_val("snd_latch", 32'(io_val[6]), 32'(snd_latch));

        test_name = "cab";
        for (int k = 0; k < 4; k++) begin
            r  = rand_word();
            r2 = rand_word();
            @(posedge clk);
            cab <= {r, r2[0]};
            for (int s = 0; s < 16; s++) wb_read({4'h4, r2[11:4], s[3:0]});
        end

        test_name = "rom";
        for (int k = 0; k < 32; k++) begin
            r = rand_word();
            if (k % 4 == 0) wb_write(16'h4008, r[31:24]);
            wb_read({4'(5 + int'(r[23:16]) % 11), r[11:0]});
        end
        wb_write(16'h9123, 8'h55);           // Dropped, only needs an ack

        test_name = "video";
        for (int k = 0; k < 8; k++) begin
            r = rand_word();
            wb_read({3'b001, r[12:0]});
            wb_write({4'h5, r[27:16]}, r[7:0]);
            wb_write({4'h7, r[27:16]}, r[15:8]);
        end

        test_name = "irq";
        @(posedge clk);
        lvbl <= 1'b0;
        @(negedge clk);
        check_val("nirq before edge", 32'(1'b1), 32'(nirq));
        @(negedge clk);
        check_val("nirq", 32'(1'b0), 32'(nirq));
        @(posedge clk);
        vmid <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check_val("nfirq", 32'(1'b0), 32'(nfirq));
        wb_write(16'h400f, 8'h00);
        @(negedge clk);
        check_val("acked lines", 32'(2'b11), 32'({nirq, nfirq}));
        @(posedge clk);
        lvbl <= 1'b1;
        vmid <= 1'b0;
        dip_pause <= 1'b0;
        @(posedge clk);
        lvbl <= 1'b0;
        vmid <= 1'b1;
        repeat (3) @(negedge clk);
        check_val("paused lines", 32'(2'b11), 32'({nirq, nfirq}));

        @(negedge clk);
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
rumble_pkg.sv
main_decode.sv
bank_map.sv
io_regs.sv
work_ram.sv
irq_gen.sv
main_bus.sv
tb_main_bus.sv

// File: run.sh
#!/bin/sh
# Builds the main bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_main_bus -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_main_bus)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
